/* Makefile */
VERILATOR  ?= verilator
TOP        ?= div_unit_tb
LINT_TOP   ?= div_unit_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/div_core_if.sv */
`timescale 1ns/1ps

interface div_core_if;

    logic        start;
    logic        flush;
    logic [63:0] dividend_mag;
    logic [63:0] divisor_mag;
    logic        ready;
    logic        done;
    logic [63:0] quotient_mag;
    logic [63:0] remainder_mag;

    // operand side.
    modport prep_mp (
        output start,
        output flush,
        output dividend_mag,
        output divisor_mag,
        input  ready
    );

    // iteration side.
    modport core_mp (
        input  start,
        input  flush,
        input  dividend_mag,
        input  divisor_mag,
        output ready,
        output done,
        output quotient_mag,
        output remainder_mag
    );

    modport result_mp (
        input done,
        input quotient_mag,
        input remainder_mag
    );

endinterface

/* rtl/div_iter_core.sv */
`timescale 1ns/1ps

module div_iter_core
    import div_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    div_core_if.core_mp core
);

    localparam int CNT_W = $clog2(DIV_STEPS + 1);

    div_state_e       state;
    logic [CNT_W-1:0] step_cnt;
    logic             at_end;
    logic             stepping;

    // upper half holds the running remainder, lower half the dividend bits
    // still to be shifted in, replaced by quotient bits from the bottom.
    logic [127:0]     part_rem;
    logic [63:0]      divisor_q;
    logic [64:0]      trial;

    assign at_end   = (step_cnt == CNT_W'(DIV_STEPS));
    assign stepping = (state == BUSY) && !at_end && !core.flush;

    // shifted remainder minus divisor, with one extra bit for the borrow.
    // the shifted remainder can reach 65 bits when the divisor is large.
    assign trial = part_rem[127:63] - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else if (core.start) begin
            state    <= BUSY;
            step_cnt <= '0;
        end else if (core.flush) begin
            state    <= IDLE;
        end else if (state == BUSY) begin
            if (at_end) begin
                state <= IDLE;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // restoring step, keep the difference only when there is no borrow.
    always_ff @(posedge clk) begin
        if (core.start) begin
            part_rem  <= {64'b0, core.dividend_mag};
            divisor_q <= core.divisor_mag;
        end else if (stepping) begin
            if (!trial[64]) begin
                part_rem <= {trial[63:0], part_rem[62:0], 1'b1};
            end else begin
                part_rem <= {part_rem[126:0], 1'b0};
            end
        end
    end

    assign core.ready = (state == IDLE);

    // a flush in the last cycle still cancels the result.
    assign core.done = (state == BUSY) && at_end && !core.flush;

    // with a zero divisor every step subtracts nothing, so the quotient
    // fills with ones and the remainder ends up as the dividend.
    assign core.quotient_mag  = part_rem[63:0];
    assign core.remainder_mag = part_rem[127:64];

endmodule

/* rtl/div_operand_prep.sv */
`timescale 1ns/1ps

module div_operand_prep
    import div_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic                flush,
    input  div_op_e             op,
    input  logic [63:0]         dividend,
    input  logic [63:0]         divisor,
    div_core_if.prep_mp         core,
    output div_ctrl_t           ctrl
);

    logic        is_signed;
    logic        is_word;
    logic        is_rem;
    logic [63:0] dividend_ext;
    logic [63:0] divisor_ext;
    logic        dividend_neg;
    logic        divisor_neg;
    logic        divisor_zero;
    logic        start;

    // operation decode.
    always_comb begin
        is_signed = (op == DIV) || (op == REM) || (op == DIVW) || (op == REMW);
        is_word   = (op == DIVW) || (op == DIVUW) || (op == REMW) || (op == REMUW);
        is_rem    = (op == REM) || (op == REMU) || (op == REMW) || (op == REMUW);
    end

    // word forms only look at the low half.
    always_comb begin
        if (!is_word) begin
            dividend_ext = dividend;
            divisor_ext  = divisor;
        end else if (is_signed) begin
            dividend_ext = {{32{dividend[31]}}, dividend[31:0]};
            divisor_ext  = {{32{divisor[31]}}, divisor[31:0]};
        end else begin
            dividend_ext = {32'b0, dividend[31:0]};
            divisor_ext  = {32'b0, divisor[31:0]};
        end
    end

    assign dividend_neg = is_signed && dividend_ext[63];
    assign divisor_neg  = is_signed && divisor_ext[63];
    assign divisor_zero = (divisor_ext == 64'b0);

    // magnitudes for the unsigned core.
    // the most negative value maps onto 2^63, which the core handles fine.
    assign core.dividend_mag = dividend_neg ? (~dividend_ext + 64'd1) : dividend_ext;
    assign core.divisor_mag  = divisor_neg ? (~divisor_ext + 64'd1) : divisor_ext;

    // a flush lets a new operation in while the core is still busy.
    assign start      = in_valid && (core.ready || flush);
    assign core.start = start;
    assign core.flush = flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (start) begin
            // quotient of x/0 stays all ones regardless of signs.
            ctrl.neg_q   <= (dividend_neg != divisor_neg) && !divisor_zero;
            ctrl.neg_r   <= dividend_neg;
            ctrl.sel_rem <= is_rem;
            ctrl.word    <= is_word;
        end
    end

endmodule

/* rtl/div_pkg.sv */
package div_pkg;

    // the eight m-extension divide operations.
    typedef enum logic [2:0] {
        DIV   = 3'd0,
        DIVU  = 3'd1,
        REM   = 3'd2,
        REMU  = 3'd3,
        DIVW  = 3'd4,
        DIVUW = 3'd5,
        REMW  = 3'd6,
        REMUW = 3'd7
    } div_op_e;

    // iteration core states.
    typedef enum logic [0:0] {
        IDLE = 1'b0,
        BUSY = 1'b1
    } div_state_e;

    // sign and format controls, captured when an operation is accepted.
    typedef struct packed {
        logic neg_q;
        logic neg_r;
        logic sel_rem;
        logic word;
    } div_ctrl_t;

    // one quotient bit per step.
    localparam int DIV_STEPS = 64;

endpackage

/* rtl/div_result_fixup.sv */
`timescale 1ns/1ps

module div_result_fixup
    import div_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    div_core_if.result_mp core,
    input  div_ctrl_t     ctrl,
    output logic          out_valid,
    output logic [63:0]   result
);

    logic [63:0] picked;
    logic        negate;
    logic [63:0] signed_val;
    logic [63:0] final_val;

    always_comb begin
        picked = ctrl.sel_rem ? core.remainder_mag : core.quotient_mag;
        negate = ctrl.sel_rem ? ctrl.neg_r : ctrl.neg_q;

        // overflow lands here too: negating 2^63 gives 2^63 back.
        signed_val = negate ? (~picked + 64'd1) : picked;

        // word results are sign-extended from bit 31.
        if (ctrl.word) begin
            final_val = {{32{signed_val[31]}}, signed_val[31:0]};
        end else begin
            final_val = signed_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= core.done;
        end
    end

    // held until the next done.
    always_ff @(posedge clk) begin
        if (core.done) begin
            result <= final_val;
        end
    end

endmodule

/* rtl/div_unit_top.sv */
`timescale 1ns/1ps

module div_unit_top
    import div_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic        flush,
    input  div_op_e     op,
    input  logic [63:0] dividend,
    input  logic [63:0] divisor,
    output logic        ready,
    output logic        out_valid,
    output logic [63:0] result
);

    div_ctrl_t ctrl;

    // prep to core to fixup.
    div_core_if core_if ();

    div_operand_prep i_div_operand_prep (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .flush    (flush),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .core     (core_if.prep_mp),
        .ctrl     (ctrl)
    );

    div_iter_core i_div_iter_core (
        .clk  (clk),
        .rst  (rst),
        .core (core_if.core_mp)
    );

    div_result_fixup i_div_result_fixup (
        .clk       (clk),
        .rst       (rst),
        .core      (core_if.result_mp),
        .ctrl      (ctrl),
        .out_valid (out_valid),
        .result    (result)
    );

    assign ready = core_if.ready;

endmodule

/* verification/div_unit_tb.sv */
`timescale 1ns/1ps

module div_unit_tb
    import div_pkg::*;
();

    localparam int NUM_RANDOM = 12;
    localparam int WAIT_LIMIT = DIV_STEPS + 10;

    typedef struct {
        div_op_e     op;
        logic [63:0] dividend;
        logic [63:0] divisor;
        int          flush_after;
        logic [63:0] expected;
    } row_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        flush;
    div_op_e     op;
    logic [63:0] dividend;
    logic [63:0] divisor;
    logic        ready;
    logic        out_valid;
    logic [63:0] result;

    row_t rows[$];
    int   seed;
    int   errors;
    int   passed;
    int   row_errors;
    logic table_ready;

    div_unit_top i_div_unit_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .flush     (flush),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (ready),
        .out_valid (out_valid),
        .result    (result)
    );

    always #2 clk = ~clk;

    // risc-v m-extension rules with the zero divisor and overflow cases first.
    function automatic logic [63:0] ref_result(div_op_e o, logic [63:0] a, logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic [31:0]        wq;
        logic [31:0]        wr;
        logic [63:0]        q;
        logic [63:0]        r;
        logic               is_word;
        sa = a;
        sb = b;
        wa = a[31:0];
        wb = b[31:0];
        q = '0;
        r = '0;
        wq = '0;
        wr = '0;
        is_word = (o == DIVW) || (o == DIVUW) || (o == REMW) || (o == REMUW);
        if (o == DIV || o == REM) begin
            if (b == 64'd0) begin
                q = '1;
                r = a;
            end else if (a == {1'b1, 63'd0} && sb == -64'sd1) begin
                q = a;
                r = '0;
            end else begin
                q = sa / sb;
                r = sa % sb;
            end
        end else if (o == DIVU || o == REMU) begin
            q = (b == 64'd0) ? '1 : a / b;
            r = (b == 64'd0) ? a : a % b;
        end else if (o == DIVW || o == REMW) begin
            if (b[31:0] == 32'd0) begin
                wq = '1;
                wr = a[31:0];
            end else if (a[31:0] == 32'h8000_0000 && wb == -32'sd1) begin
                wq = a[31:0];
                wr = '0;
            end else begin
                wq = wa / wb;
                wr = wa % wb;
            end
        end else begin
            wq = (b[31:0] == 32'd0) ? '1 : a[31:0] / b[31:0];
            wr = (b[31:0] == 32'd0) ? a[31:0] : a[31:0] % b[31:0];
        end
        if (is_word) begin
            q = {{32{wq[31]}}, wq};
            r = {{32{wr[31]}}, wr};
        end
        return (o == REM || o == REMU || o == REMW || o == REMUW) ? r : q;
    endfunction

    task automatic add_row(input div_op_e o, input logic [63:0] a, input logic [63:0] b,
                           input int flush_after);
        row_t row;
        row.op          = o;
        row.dividend    = a;
        row.divisor     = b;
        row.flush_after = flush_after;
        row.expected    = ref_result(o, a, b);
        rows.push_back(row);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [63:0] a;
        logic [63:0] b;
        int          shift;
        // mixed signs where the remainder follows the dividend.
        add_row(DIV, 64'd100, -64'sd7, 0);
        add_row(REM, -64'sd100, 64'd7, 0);
        add_row(DIV, -64'sd9, -64'sd2, 0);
        add_row(REM, 64'd9, -64'sd4, 0);
        add_row(DIVU, 64'hFFFF_FFFF_FFFF_FFFF, 64'd3, 0);
        add_row(REMU, 64'd12345678901, 64'd1000, 0);
        // word forms ignore the upper half.
        add_row(DIVW, 64'hFFFF_FFFF_0000_0064, 64'h1234_5678_FFFF_FFF9, 0);
        add_row(REMW, 64'h0BAD_0000_FFFF_FF9C, 64'h7777_0000_0000_0007, 0);
        add_row(DIVUW, 64'h5555_0000_F000_0000, 64'hAAAA_0000_0000_0001, 0);
        add_row(REMUW, 64'h0000_0000_FFFF_FFFF, 64'h0000_0001_0000_000A, 0);
        // zero divisor.
        add_row(DIV, -64'sd77, 64'd0, 0);
        add_row(DIVU, 64'd77, 64'd0, 0);
        add_row(REM, -64'sd77, 64'd0, 0);
        add_row(REMU, 64'hDEAD_BEEF_0000_0001, 64'd0, 0);
        add_row(DIVW, 64'h0000_0000_8000_0001, 64'hABCD_0000_0000_0000, 0);
        add_row(REMW, 64'h1111_2222_8000_0001, 64'hABCD_0000_0000_0000, 0);
        add_row(DIVUW, 64'h1111_2222_3333_4444, 64'hFFFF_FFFF_0000_0000, 0);
        add_row(REMUW, 64'h1111_2222_9333_4444, 64'hFFFF_FFFF_0000_0000, 0);
        // most negative value divided by -1.
        add_row(DIV, 64'h8000_0000_0000_0000, -64'sd1, 0);
        add_row(REM, 64'h8000_0000_0000_0000, -64'sd1, 0);
        add_row(DIVW, 64'h0000_0000_8000_0000, 64'h0000_0000_FFFF_FFFF, 0);
        add_row(REMW, 64'hFFFF_FFFF_8000_0000, 64'h0000_0000_FFFF_FFFF, 0);
        // cancelled operations each followed by a different one.
        add_row(DIV, 64'd5000, 64'd3, 1);
        add_row(REM, -64'sd5000, 64'd7, 0);
        add_row(REMU, 64'd999, 64'd10, 20);
        add_row(DIVU, 64'd999, 64'd10, 0);
        add_row(DIVW, 64'd1234, -64'sd5, 64);
        add_row(REMW, 64'd1234, -64'sd5, 0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd   = $random(seed);
            a     = {$random(seed), $random(seed)};
            b     = {$random(seed), $random(seed)};
            shift = $random(seed) & 63;
            add_row(div_op_e'(rnd[2:0]), a, b >> shift, 0);
        end
    endtask

    task automatic check_result(input div_op_e o, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s returned %h, expected %h", $time, o.name(), got, exp);
            row_errors++;
        end
    endtask

    task automatic check_latency(input div_op_e o, input int cycles, input logic rdy,
                                 input logic early);
        if (cycles != DIV_STEPS + 1 || rdy !== 1'b1 || early) begin
            $display("Fail at %0t ns: %s out_valid after %0d cycles, ready %b, early ready %b",
                     $time, o.name(), cycles, rdy, early);
            row_errors++;
        end
    endtask

    task automatic check_cancelled(input div_op_e o, input logic seen);
        if (seen) begin
            $display("Fail at %0t ns: %s raised out_valid after a flush", $time, o.name());
            row_errors++;
        end
    endtask

    task automatic run_row(input int idx);
        row_t row;
        int   cycles;
        logic seen;
        logic early_ready;
        row         = rows[idx];
        row_errors  = 0;
        cycles      = 0;
        seen        = 1'b0;
        early_ready = 1'b0;
        while (!ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("row %0d: the unit never became ready", idx);
            row_errors++;
        end else begin
            op       = row.op;
            dividend = row.dividend;
            divisor  = row.divisor;
            in_valid = 1'b1;
            @(negedge clk);
            in_valid = 1'b0;
            if (row.flush_after == 0) begin
                cycles = 0;
                do begin
                    @(negedge clk);
                    cycles++;
                    // ready must stay low while the core is still working.
                    if (!out_valid && ready) begin
                        early_ready = 1'b1;
                    end
                end while (!out_valid && cycles < WAIT_LIMIT);
                if (!out_valid) begin
                    $display("row %0d: no out_valid within %0d cycles", idx, WAIT_LIMIT);
                    row_errors++;
                end else begin
                    check_latency(row.op, cycles, ready, early_ready);
                    check_result(row.op, result, row.expected);
                end
            end else begin
                repeat (row.flush_after) begin
                    @(negedge clk);
                    seen |= out_valid;
                end
                flush = 1'b1;
                @(negedge clk);
                seen |= out_valid;
                flush = 1'b0;
                // watch past the point where the result would have come.
                repeat (DIV_STEPS + 2 - row.flush_after) begin
                    @(negedge clk);
                    seen |= out_valid;
                end
                check_cancelled(row.op, seen);
            end
        end
        if (row_errors == 0) begin
            passed++;
            $display("row %0d %s flush %0d: ok", idx, row.op.name(), row.flush_after);
        end else begin
            errors++;
            $display("row %0d %s flush %0d: failed", idx, row.op.name(), row.flush_after);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        flush       = 1'b0;
        op          = DIV;
        dividend    = '0;
        divisor     = '0;
        seed        = 82472;
        errors      = 0;
        passed      = 0;
        row_errors  = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("after reset ready is %b and out_valid is %b", ready, out_valid);
            errors++;
        end
        foreach (rows[i]) begin
            run_row(i);
        end
        $display("tests %0d, passed %0d, failed %0d", rows.size(), passed, rows.size() - passed);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // each row needs at most DIV_STEPS plus a few cycles.
    initial begin
        wait (table_ready);
        repeat (rows.size() * (DIV_STEPS + 10) + 20) @(posedge clk);
        $display("watchdog expired before all rows finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog.f */
rtl/div_pkg.sv
rtl/div_core_if.sv
rtl/div_operand_prep.sv
rtl/div_iter_core.sv
rtl/div_result_fixup.sv
rtl/div_unit_top.sv
verification/div_unit_tb.sv
